// File: hw/pcs_params_pkg.sv
package pcs_params_pkg;

        // high error-rate detection over a window of received blocks.
        localparam int HI_BER_VALUE     = 97;
        localparam int XUS_TIMER_WINDOW = 1024;

        // block lock acquisition and hold.
        localparam int LOCK_GOOD_SH     = 64;   // consecutive good headers to gain lock.
        localparam int SLIP_WINDOW      = 64;   // blocks per lock-hold window.
        localparam int SLIP_BAD_SH      = 16;   // bad headers per window that lose lock.

        // counter widths. The window counters carry one spare bit.
        localparam int NB_BER_CNT       = $clog2(XUS_TIMER_WINDOW) + 1;
        localparam int NB_XUS_TIMER     = $clog2(XUS_TIMER_WINDOW) + 1;
        localparam int NB_SH_CNT        = 7;

        // statistics counters seen by software.
        localparam int NB_STAT_BER      = 6;
        localparam int NB_STAT_EVT      = 8;

endpackage

// File: hw/pcs_types_pkg.sv
package pcs_types_pkg;

        import pcs_params_pkg::*;

        // counters of the error-rate monitor.
        typedef logic [NB_BER_CNT-1:0]   ber_cnt_t;
        typedef logic [NB_XUS_TIMER-1:0] xus_timer_t;

        // counters of the block-lock machine.
        typedef logic [NB_SH_CNT-1:0]    sh_cnt_t;

        // statistics.
        typedef logic [NB_STAT_BER-1:0]  stat_ber_t;    // bad headers seen while locked.
        typedef logic [NB_STAT_EVT-1:0]  stat_evt_t;    // hi_ber assertions.

        typedef enum logic [1:0]
        {
                INIT,
                TEST,
                HI_BER
        } ber_state_e;

        typedef enum logic
        {
                UNLOCKED,
                LOCKED
        } lock_state_e;

endpackage

// File: hw/block_lock.sv
`timescale 1ns/1ps

module block_lock
        import pcs_params_pkg::*;
        import pcs_types_pkg::*;
(
        input  logic i_clock,
        input  logic i_rst,
        input  logic i_valid,
        input  logic i_valid_sh,
        output logic o_block_lock,
        output logic o_slip
);

        lock_state_e state;
        sh_cnt_t     good_cnt;          // consecutive good headers while hunting.
        sh_cnt_t     win_cnt;           // blocks seen in the current hold window.
        sh_cnt_t     bad_cnt;           // bad headers in the current hold window.
        logic        bad_sh;
        logic        lock_found;
        logic        lock_lost;
        logic        win_end;

        assign bad_sh     = i_valid && !i_valid_sh;
        assign lock_found = i_valid && i_valid_sh &&
                            (good_cnt == sh_cnt_t'(LOCK_GOOD_SH - 1));
        assign lock_lost  = bad_sh && (bad_cnt == sh_cnt_t'(SLIP_BAD_SH - 1));
        assign win_end    = i_valid && (win_cnt == sh_cnt_t'(SLIP_WINDOW - 1));

        always_ff @(posedge i_clock)
        begin
                if (i_rst)
                begin
                        state    <= UNLOCKED;
                        o_slip   <= 1'b0;
                        good_cnt <= '0;
                        win_cnt  <= '0;
                        bad_cnt  <= '0;
                end
                else
                begin
                        o_slip <= 1'b0;
                        case (state)
                                UNLOCKED:
                                begin
                                        if (bad_sh)
                                        begin
                                                // a slip in flight absorbs a
                                                // bad header right behind it.
                                                good_cnt <= '0;
                                                o_slip   <= !o_slip;
                                        end
                                        else if (lock_found)
                                        begin
                                                state    <= LOCKED;
                                                good_cnt <= '0;
                                                win_cnt  <= '0;
                                                bad_cnt  <= '0;
                                        end
                                        else if (i_valid)
                                        begin
                                                good_cnt <= good_cnt + 1'b1;
                                        end
                                end
                                LOCKED:
                                begin
                                        if (lock_lost)
                                        begin
                                                state   <= UNLOCKED;
                                                o_slip  <= 1'b1;
                                                win_cnt <= '0;
                                                bad_cnt <= '0;
                                        end
                                        else if (win_end)
                                        begin
                                                // window closed below the limit.
                                                win_cnt <= '0;
                                                bad_cnt <= '0;
                                        end
                                        else if (i_valid)
                                        begin
                                                win_cnt <= win_cnt + 1'b1;
                                                if (bad_sh)
                                                        bad_cnt <= bad_cnt + 1'b1;
                                        end
                                end
                        endcase
                end
        end

        assign o_block_lock = (state == LOCKED);

        // The slip logic downstream needs a gap between two requests.
        a_slip_single : assert property (@(posedge i_clock) disable iff (i_rst)
                o_slip |=> !o_slip);

        // A slip is only ever decided by a received block.
        a_slip_after_valid : assert property (@(posedge i_clock) disable iff (i_rst)
                o_slip |-> $past(i_valid));

endmodule

// File: hw/ber_monitor.sv
`timescale 1ns/1ps

module ber_monitor
        import pcs_params_pkg::*;
        import pcs_types_pkg::*;
(
        input  logic i_clock,
        input  logic i_rst,
        input  logic i_valid,
        input  logic i_valid_sh,
        input  logic i_test_mode,       // idle pattern test, freezes the window.
        input  logic i_deskew_done,
        output logic o_hi_ber
);

        ber_state_e state;
        ber_state_e next_state;
        ber_cnt_t   ber_cnt;
        xus_timer_t xus_timer;
        logic       xus_timer_done;
        logic       reset_timer;
        logic       hi_ber;
        logic       hi_ber_next;

        // the machine only advances on received blocks.
        always_ff @(posedge i_clock)
        begin
                if (i_rst || !i_deskew_done)
                        state <= INIT;
                else if (i_valid)
                        state <= next_state;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_rst || !i_deskew_done || xus_timer_done)
                        ber_cnt <= '0;
                else if (i_valid && !i_valid_sh && (ber_cnt != '1))
                        ber_cnt <= ber_cnt + 1'b1;    // saturates during long test runs.
        end

        always_ff @(posedge i_clock)
        begin
                if (i_rst || !i_deskew_done || xus_timer_done || i_test_mode || reset_timer)
                        xus_timer <= '0;
                else if (i_valid)
                        xus_timer <= xus_timer + 1'b1;
        end

        assign xus_timer_done = i_valid &&
                                (xus_timer == xus_timer_t'(XUS_TIMER_WINDOW - 1));

        always_ff @(posedge i_clock)
        begin
                if (i_rst || !i_deskew_done)
                        hi_ber <= 1'b0;
                else
                        hi_ber <= hi_ber_next;
        end

        assign o_hi_ber = hi_ber;

        always_comb
        begin
                next_state  = state;
                reset_timer = 1'b0;
                hi_ber_next = hi_ber;
                case (state)
                        INIT:
                        begin
                                next_state  = TEST;
                                reset_timer = 1'b1;
                        end
                        TEST:
                        begin
                                if (ber_cnt >= ber_cnt_t'(HI_BER_VALUE))
                                        next_state = HI_BER;
                                else if (xus_timer_done)
                                        hi_ber_next = 1'b0;     // a clean window ends.
                        end
                        HI_BER:
                        begin
                                hi_ber_next = 1'b1;
                                if (xus_timer_done)
                                        next_state = INIT;
                        end
                        default:
                        begin
                                next_state = INIT;
                        end
                endcase
        end

        // Losing deskew must drop the flag right away, whatever the state.
        a_deskew_clears : assert property (@(posedge i_clock) disable iff (i_rst)
                !i_deskew_done |=> !o_hi_ber);

endmodule

// File: hw/pcs_status.sv
`timescale 1ns/1ps

module pcs_status
        import pcs_params_pkg::*;
        import pcs_types_pkg::*;
(
        input  logic      i_clock,
        input  logic      i_rst,
        input  logic      i_valid,
        input  logic      i_valid_sh,
        input  logic      i_deskew_done,
        input  logic      i_block_lock,
        input  logic      i_hi_ber,
        input  logic      i_stat_clear,
        output logic      o_link_up,
        output stat_ber_t o_ber_count,
        output stat_evt_t o_hi_ber_events
);

        logic hi_ber_q;
        logic hi_ber_rise;
        logic ber_count_max;
        logic events_max;

        assign hi_ber_rise   = i_hi_ber && !hi_ber_q;
        assign ber_count_max = (o_ber_count == stat_ber_t'({NB_STAT_BER{1'b1}}));
        assign events_max    = (o_hi_ber_events == stat_evt_t'({NB_STAT_EVT{1'b1}}));

        always_ff @(posedge i_clock)
        begin
                if (i_rst)
                begin
                        o_link_up <= 1'b0;
                        hi_ber_q  <= 1'b0;
                end
                else
                begin
                        o_link_up <= i_block_lock && !i_hi_ber && i_deskew_done;
                        hi_ber_q  <= i_hi_ber;
                end
        end

        // bad headers only count once the block boundary is trusted.
        always_ff @(posedge i_clock)
        begin
                if (i_rst || i_stat_clear)
                        o_ber_count <= '0;
                else if (i_valid && !i_valid_sh && i_block_lock && !ber_count_max)
                        o_ber_count <= o_ber_count + 1'b1;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_rst || i_stat_clear)
                        o_hi_ber_events <= '0;
                else if (hi_ber_rise && !events_max)
                        o_hi_ber_events <= o_hi_ber_events + 1'b1;
        end

        // link-up follows hi_ber by one register, so it is down a cycle later.
        a_hi_ber_drops_link : assert property (@(posedge i_clock) disable iff (i_rst)
                i_hi_ber |=> !o_link_up);

endmodule

// File: hw/pcs_rx_monitor.sv
`timescale 1ns/1ps

module pcs_rx_monitor
        import pcs_params_pkg::*;
        import pcs_types_pkg::*;
(
        input  logic      i_clock,
        input  logic      i_rst,
        input  logic      i_valid,
        input  logic      i_valid_sh,
        input  logic      i_deskew_done,
        input  logic      i_test_mode,
        input  logic      i_stat_clear,
        output logic      o_slip,
        output logic      o_block_lock,
        output logic      o_hi_ber,
        output logic      o_link_up,
        output stat_ber_t o_ber_count,
        output stat_evt_t o_hi_ber_events
);

        block_lock u_block_lock
        (
                .i_clock      (i_clock),
                .i_rst        (i_rst),
                .i_valid      (i_valid),
                .i_valid_sh   (i_valid_sh),
                .o_block_lock (o_block_lock),
                .o_slip       (o_slip)
        );

        ber_monitor u_ber_monitor
        (
                .i_clock       (i_clock),
                .i_rst         (i_rst),
                .i_valid       (i_valid),
                .i_valid_sh    (i_valid_sh),
                .i_test_mode   (i_test_mode),
                .i_deskew_done (i_deskew_done),
                .o_hi_ber      (o_hi_ber)
        );

        pcs_status u_pcs_status
        (
                .i_clock         (i_clock),
                .i_rst           (i_rst),
                .i_valid         (i_valid),
                .i_valid_sh      (i_valid_sh),
                .i_deskew_done   (i_deskew_done),
                .i_block_lock    (o_block_lock),
                .i_hi_ber        (o_hi_ber),
                .i_stat_clear    (i_stat_clear),
                .o_link_up       (o_link_up),
                .o_ber_count     (o_ber_count),
                .o_hi_ber_events (o_hi_ber_events)
        );

endmodule

// File: sim/tb_pcs_rx_monitor.sv
`timescale 1ns/1ps

module tb_pcs_rx_monitor
        import pcs_params_pkg::*;
();

        localparam int SETTLE_TIMEOUT = 50;     // clocks allowed for the output levels to settle.
        localparam int BER_COUNT_MAX  = (1 << NB_STAT_BER) - 1;
        localparam int EVENTS_MAX     = (1 << NB_STAT_EVT) - 1;

        typedef struct packed
        {
                int   blocks;
                int   bad_every;                // 0 means no bad headers.
                logic test_mode;
                logic deskew;
                logic clear;
                logic exp_lock;
                logic exp_hi;
                logic exp_link;
                int   exp_ber;
                int   exp_evt;
        } phase_t;

        logic clock;
        logic rst;
        logic valid;
        logic valid_sh;
        logic deskew_done;
        logic test_mode;
        logic stat_clear;
        logic slip;
        logic block_lock;
        logic hi_ber;
        logic link_up;
        logic [NB_STAT_BER-1:0] ber_count;
        logic [NB_STAT_EVT-1:0] hi_ber_events;

        phase_t phases[$];
        int     mismatch_count = 0;
        int     timeout_count  = 0;
        int     slip_count     = 0;

        // reference model state, advanced once per received block.
        bit m_locked = 0;
        int m_good   = 0;
        int m_win    = 0;
        int m_bad    = 0;
        int m_slips  = 0;
        int m_state  = 0;                       // 0 INIT, 1 TEST, 2 HI_BER.
        int m_cnt    = 0;
        int m_timer  = 0;
        bit m_hi     = 0;
        int m_ber_count = 0;
        int m_events    = 0;

        pcs_rx_monitor DUT
        (
                .i_clock         (clock),
                .i_rst           (rst),
                .i_valid         (valid),
                .i_valid_sh      (valid_sh),
                .i_deskew_done   (deskew_done),
                .i_test_mode     (test_mode),
                .i_stat_clear    (stat_clear),
                .o_slip          (slip),
                .o_block_lock    (block_lock),
                .o_hi_ber        (hi_ber),
                .o_link_up       (link_up),
                .o_ber_count     (ber_count),
                .o_hi_ber_events (hi_ber_events)
        );

        always #5 clock = ~clock;

        always @(negedge clock)
        begin
                if (!rst && slip)
                        slip_count++;
        end

        task automatic add_phase(input int blocks, input int bad_every, input logic tm,
                                 input logic dsk, input logic clr, input logic lock,
                                 input logic hi, input logic link, input int ber, input int evt);
                phase_t p;
                p = {blocks, bad_every, tm, dsk, clr, lock, hi, link, ber, evt};
                phases.push_back(p);
        endtask

        task automatic compare(input string name, input int idx, input logic [31:0] got,
                               input logic [31:0] exp);
                if (got !== exp)
                begin
                        $display("Mismatch %s in phase %0d: got 0x%0h, expected 0x%0h",
                                 name, idx, got, exp);
                        mismatch_count++;
                end
        endtask

        task automatic model_block(input bit bad, input bit tm, input bit dsk);
                int next_state;
                bit window_done;
                // the statistics see the lock level from before this block.
                if (bad && m_locked && m_ber_count < BER_COUNT_MAX)
                        m_ber_count++;
                if (!m_locked)
                begin
                        if (bad)
                        begin
                                m_good = 0;
                                m_slips++;
                        end
                        else if (m_good == LOCK_GOOD_SH - 1)
                        begin
                                m_locked = 1;
                                m_good   = 0;
                                m_win    = 0;
                                m_bad    = 0;
                        end
                        else
                                m_good++;
                end
                else if (bad && m_bad == SLIP_BAD_SH - 1)
                begin
                        m_locked = 0;
                        m_slips++;
                        m_win = 0;
                        m_bad = 0;
                end
                else if (m_win == SLIP_WINDOW - 1)
                begin
                        m_win = 0;
                        m_bad = 0;
                end
                else
                begin
                        m_win++;
                        if (bad)
                                m_bad++;
                end
                if (!dsk)
                        return;
                window_done = (m_timer == XUS_TIMER_WINDOW - 1);
                next_state  = m_state;
                if (m_state == 0)
                        next_state = 1;
                else if (m_state == 1)
                begin
                        if (m_cnt >= HI_BER_VALUE)
                                next_state = 2;
                        else if (window_done)
                                m_hi = 0;       // a clean window clears the flag.
                end
                else if (window_done)
                        next_state = 0;
                if (window_done)
                        m_cnt = 0;
                else if (bad)
                        m_cnt++;
                if (window_done || tm || m_state == 0)
                        m_timer = 0;
                else
                        m_timer++;
                m_state = next_state;
                if (m_state == 2 && !m_hi)
                begin
                        m_hi = 1;
                        if (m_events < EVENTS_MAX)
                                m_events++;
                end
        endtask

        task automatic settle_outputs(input phase_t p, input int idx);
                int   cycles;
                logic exp_link;
                exp_link = m_locked && !m_hi && p.deskew;
                cycles   = 0;
                while ((hi_ber !== m_hi || link_up !== exp_link) && cycles < SETTLE_TIMEOUT)
                begin
                        @(negedge clock);
                        cycles++;
                end
                if (hi_ber !== m_hi || link_up !== exp_link)
                begin
                        $display("Timeout: o_hi_ber and o_link_up did not settle after phase %0d",
                                 idx);
                        timeout_count++;
                end
                repeat (2) @(negedge clock);    // counters trail the levels by one clock.
        endtask

        task automatic check_phase(input phase_t p, input int idx);
                compare("o_block_lock", idx, block_lock, p.exp_lock);
                compare("o_hi_ber", idx, hi_ber, p.exp_hi);
                compare("o_link_up", idx, link_up, p.exp_link);
                compare("o_ber_count", idx, ber_count, p.exp_ber);
                compare("o_hi_ber_events", idx, hi_ber_events, p.exp_evt);
                compare("o_block_lock vs model", idx, block_lock, m_locked);
                compare("o_hi_ber vs model", idx, hi_ber, m_hi);
                compare("o_ber_count vs model", idx, ber_count, m_ber_count);
                compare("o_hi_ber_events vs model", idx, hi_ber_events, m_events);
                compare("o_slip pulse count", idx, slip_count, m_slips);
        endtask

        task automatic run_phase(input phase_t p, input int idx);
                int gap;
                bit bad;
                @(negedge clock);
                test_mode   = p.test_mode;
                deskew_done = p.deskew;
                stat_clear  = p.clear;
                if (p.clear)
                begin
                        m_ber_count = 0;
                        m_events    = 0;
                end
                if (!p.deskew)
                begin
                        m_state = 0;
                        m_cnt   = 0;
                        m_timer = 0;
                        m_hi    = 0;
                end
                if (p.test_mode)
                        m_timer = 0;
                @(negedge clock);
                stat_clear = 1'b0;
                for (int n = 0; n < p.blocks; n++)
                begin
                        gap = 1 + ($urandom % 3);
                        repeat (gap) @(negedge clock);
                        bad      = (p.bad_every != 0) && ((n + 1) % p.bad_every == 0);
                        valid    = 1'b1;
                        valid_sh = !bad;
                        model_block(bad, p.test_mode, p.deskew);
                        @(negedge clock);
                        valid    = 1'b0;
                        valid_sh = 1'b1;
                end
                settle_outputs(p, idx);
                check_phase(p, idx);
        endtask

        initial
        begin
                void'($urandom(32'h7a85_be11));
                clock       = 1'b0;
                rst         = 1'b1;
                valid       = 1'b0;
                valid_sh    = 1'b1;
                deskew_done = 1'b0;
                test_mode   = 1'b0;
                stat_clear  = 1'b0;
                // blocks, bad every, test, deskew, clear, lock, hi_ber, link, ber count, events
                add_phase(   0,  0, 0, 0, 0, 0, 0, 0,  0, 0);
                add_phase(  50, 50, 0, 1, 0, 0, 0, 0,  0, 0);   // one bad header delays lock.
                add_phase(  64,  0, 0, 1, 0, 1, 0, 1,  0, 0);
                add_phase( 128,  8, 0, 1, 0, 1, 0, 1, 16, 0);
                add_phase(  64,  4, 0, 1, 1, 0, 0, 0, 16, 0);   // sixteen bad in a window.
                add_phase(  64,  0, 0, 1, 0, 1, 0, 1, 16, 0);
                add_phase( 600,  8, 0, 1, 1, 1, 1, 0, 63, 1);
                add_phase(1100,  0, 0, 1, 0, 1, 0, 1, 63, 1);
                add_phase( 800,  8, 0, 1, 0, 1, 1, 0, 63, 2);
                add_phase(2200,  0, 1, 1, 0, 1, 1, 0, 63, 2);   // test mode freezes the window.
                add_phase(2100,  0, 0, 1, 0, 1, 0, 1, 63, 2);
                add_phase( 800,  8, 0, 1, 0, 1, 1, 0, 63, 3);
                add_phase(  10,  0, 0, 0, 0, 1, 0, 0, 63, 3);
                add_phase(  40,  4, 0, 1, 1, 1, 0, 1, 10, 0);
                add_phase( 480,  8, 0, 1, 0, 1, 0, 1, 63, 0);
                add_phase(  20,  0, 0, 1, 1, 1, 0, 1,  0, 0);
                repeat (10) @(negedge clock);
                rst = 1'b0;
                foreach (phases[i])
                        run_phase(phases[i], i);
                $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
                if (mismatch_count == 0 && timeout_count == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

// File: filelist.f
hw/pcs_params_pkg.sv
hw/pcs_types_pkg.sv
hw/block_lock.sv
hw/ber_monitor.sv
hw/pcs_status.sv
hw/pcs_rx_monitor.sv
sim/tb_pcs_rx_monitor.sv

// File: Bender.yml
package:
  name: pcs_rx_monitor

sources:
  # packages come first, the types package imports the parameters.
  - hw/pcs_params_pkg.sv
  - hw/pcs_types_pkg.sv

  # RTL, leaf modules before the top level.
  - hw/block_lock.sv
  - hw/ber_monitor.sv
  - hw/pcs_status.sv
  - hw/pcs_rx_monitor.sv

  - target: simulation
    files:
      - sim/tb_pcs_rx_monitor.sv
